//--- include/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Default base address of the four-word register window
`define UART_ADDR_BASE 16'h0040

// Register offsets inside the window
`define UART_REG_CTRL 2'd0
`define UART_REG_BAUD 2'd1
`define UART_REG_DATA 2'd2

// Entries per FIFO
`define UART_FIFO_DEPTH 4

// Control register bit positions on write
`define UART_CTRL_TXEN 7
`define UART_CTRL_RXEN 6
`define UART_CTRL_STOP2 3
`define UART_CTRL_IRQEN 1:0

`endif

//--- logic/uartPkg.sv
package uartPkg;

  // Bus request, one strobe per cycle
  typedef struct packed {
    logic [15:0] ioAddr;
    logic [15:0] ioMosi;
    logic        wr;
    logic        rd;
  } ioReqT;

  // Live configuration shared by both codec halves
  typedef struct packed {
    logic        txEn;
    logic        rxEn;
    logic        stop2;
    // Clock cycles per bit, 4 or more
    logic [15:0] baud;
  } uartCfgT;

  // Received item as it sits in the receive FIFO
  // stopErr lands on bit 8 of a data read
  typedef struct packed {
    logic       stopErr;
    logic [7:0] data;
  } rxFrameT;

endpackage

//--- logic/uartFifo.sv
`include "uart_macros.svh"

module uartFifo #(
  parameter type payloadT = logic [7:0]
) (
  input  logic    AClkH,
  input  logic    reset,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    notEmpty,
  output logic    notFull
);

  localparam int Depth = `UART_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);

  payloadT         mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            doPush;
  logic            doPop;

  assign notEmpty = count != '0;
  assign notFull  = count != (PtrW + 1)'(Depth);
  assign doPush   = push & notFull;
  assign doPop    = pop & notEmpty;

  // Head entry visible before the pop
  assign popData = mem[rdPtr];

  always_ff @(posedge AClkH) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

  always_ff @(posedge AClkH) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop) count <= count + 1'b1;
      else if (doPop && !doPush) count <= count - 1'b1;
    end
  end

endmodule

//--- logic/uartTx.sv
module uartTx (
  input  logic             AClkH,
  input  logic             reset,
  input  uartPkg::uartCfgT cfg,
  input  logic [7:0]       sendData,
  input  logic             sendReady,
  output logic             sendPop,
  output logic             busy,
  output logic             txPin
);

  // Frame bits kept inverted, so zero after reset is an idle line
  logic [8:0]  shiftInv;
  logic [15:0] baudCnt;
  // Bits left in the frame, the current one included
  logic [3:0]  bitIdx;
  logic        idle;
  logic        bitEnd;

  assign idle   = bitIdx == '0;
  assign bitEnd = ~idle & (baudCnt == '0);

  assign sendPop = idle & cfg.txEn & sendReady;
  assign busy    = ~idle | sendPop;

  // TxEn low forces a high line, the frame keeps running underneath
  assign txPin = ~(shiftInv[0] & cfg.txEn);

  always_ff @(posedge AClkH) begin
    if (reset) begin
      shiftInv <= '0;
      baudCnt  <= '0;
      bitIdx   <= '0;
    end else if (sendPop) begin
      // Low start bit in front of the data byte
      shiftInv <= {~sendData, 1'b1};
      baudCnt  <= cfg.baud - 1'b1;
      bitIdx   <= cfg.stop2 ? 4'd11 : 4'd10;
    end else if (bitEnd) begin
      // Zeros shifted in give the high stop bits
      shiftInv <= {1'b0, shiftInv[8:1]};
      bitIdx   <= bitIdx - 1'b1;
      baudCnt  <= (bitIdx == 4'd1) ? '0 : cfg.baud - 1'b1;
    end else if (!idle) begin
      baudCnt <= baudCnt - 1'b1;
    end
  end

endmodule

//--- logic/uartRx.sv
module uartRx (
  input  logic             AClkH,
  input  logic             reset,
  input  uartPkg::uartCfgT cfg,
  input  logic             rxPin,
  output logic             recvPush,
  output uartPkg::rxFrameT recvData
);

  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData
  } rxStateT;

  rxStateT     state;
  // Two synchronizer flops plus one for edge history
  logic [2:0]  rxSync;
  logic        rxBit;
  logic        rxFall;
  logic        sampleNow;
  logic [15:0] baudCnt;
  // Data bits plus the stop bit still to sample
  logic [3:0]  bitIdx;
  logic [7:0]  shiftReg;

  assign rxBit     = rxSync[1];
  assign rxFall    = rxSync[2] & ~rxSync[1];
  assign sampleNow = baudCnt == '0;

  // Push at the stop sample
  assign recvPush = cfg.rxEn & (state == rxData) & sampleNow & (bitIdx == 4'd1);
  assign recvData.data    = shiftReg;
  assign recvData.stopErr = ~rxBit;

  always_ff @(posedge AClkH) begin
    if (reset) begin
      rxSync  <= '1;
      state   <= rxIdle;
      baudCnt <= '0;
      bitIdx  <= '0;
    end else begin
      rxSync <= {rxSync[1:0], rxPin};
      if (!cfg.rxEn) begin
        state   <= rxIdle;
        baudCnt <= '0;
      end else begin
        case (state)
          rxIdle: begin
            // Half a bit time to reach the middle of the start bit
            if (rxFall) begin
              state   <= rxStart;
              baudCnt <= {1'b0, cfg.baud[15:1]} - 1'b1;
            end
          end
          rxStart: begin
            if (!sampleNow) begin
              baudCnt <= baudCnt - 1'b1;
            end else if (rxBit) begin
              // Glitch, line is high again
              state <= rxIdle;
            end else begin
              state   <= rxData;
              baudCnt <= cfg.baud - 1'b1;
              bitIdx  <= 4'd9;
            end
          end
          rxData: begin
            if (!sampleNow) begin
              baudCnt <= baudCnt - 1'b1;
            end else if (bitIdx == 4'd1) begin
              state <= rxIdle;
            end else begin
              bitIdx  <= bitIdx - 1'b1;
              baudCnt <= cfg.baud - 1'b1;
            end
          end
          default: state <= rxIdle;
        endcase
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge AClkH) begin
    if (state == rxData && sampleNow && bitIdx != 4'd1) begin
      shiftReg <= {rxBit, shiftReg[7:1]};
    end
  end

endmodule

//--- logic/uartRegs.sv
`include "uart_macros.svh"

module uartRegs #(
  parameter logic [15:0] addrBase = `UART_ADDR_BASE
) (
  input  logic              AClkH,
  input  logic              reset,
  input  uartPkg::ioReqT    ioReq,
  output logic [15:0]       ioMiso,
  output logic              ioAddrAck,
  output logic              ioAddrErr,
  output logic              irq,
  output uartPkg::uartCfgT  cfg,
  output logic              sendPush,
  input  logic              sendNotFull,
  output logic              recvPop,
  input  uartPkg::rxFrameT  recvHead,
  input  logic              recvNotEmpty,
  input  logic              sendBusy
);

  logic [15:0] relAddr;
  logic [1:0]  offset;
  logic        inWindow;
  logic        ctrlHit;
  logic        baudHit;
  logic        dataHit;
  logic [1:0]  irqEn;
  logic [1:0]  flags;
  logic [1:0]  flagsQ;
  logic [15:0] ctrlView;

  // Window of four words starting at addrBase
  assign relAddr  = ioReq.ioAddr - addrBase;
  assign offset   = relAddr[1:0];
  assign inWindow = (relAddr[15:2] == '0) & (ioReq.wr | ioReq.rd);

  assign ctrlHit = inWindow & (offset == `UART_REG_CTRL);
  assign baudHit = inWindow & (offset == `UART_REG_BAUD);
  assign dataHit = inWindow & (offset == `UART_REG_DATA);

  assign ioAddrAck = ctrlHit | baudHit | dataHit;
  // Only offset 3 is left inside the window
  assign ioAddrErr = inWindow & ~ioAddrAck;

  // FIFO strobes, a write to a full send FIFO is dropped here
  assign sendPush = ioReq.wr & dataHit & sendNotFull;
  assign recvPop  = ioReq.rd & dataHit & recvNotEmpty;

  // CanWrite and CanRead
  assign flags = {sendNotFull, recvNotEmpty};

  assign ctrlView = {8'h00, cfg.txEn, cfg.rxEn, 2'b00, sendBusy, 1'b0, flags};

  always_comb begin
    ioMiso = '0;
    if (ioReq.rd) begin
      if (ctrlHit) ioMiso = ctrlView;
      if (baudHit) ioMiso = cfg.baud;
      if (dataHit && recvNotEmpty) ioMiso = {7'h00, recvHead};
    end
  end

  always_ff @(posedge AClkH) begin
    if (reset) begin
      cfg    <= '0;
      irqEn  <= '0;
      flagsQ <= '0;
    end else begin
      if (ioReq.wr && ctrlHit) begin
        cfg.txEn  <= ioReq.ioMosi[`UART_CTRL_TXEN];
        cfg.rxEn  <= ioReq.ioMosi[`UART_CTRL_RXEN];
        cfg.stop2 <= ioReq.ioMosi[`UART_CTRL_STOP2];
        irqEn     <= ioReq.ioMosi[`UART_CTRL_IRQEN];
      end
      if (ioReq.wr && baudHit) begin
        cfg.baud <= ioReq.ioMosi;
      end
      flagsQ <= flags;
    end
  end

  // Flags lag one cycle, the enable acts at once
  assign irq = |(flagsQ & irqEn);

endmodule

//--- logic/ioUart.sv
`include "uart_macros.svh"

module ioUart #(
  parameter logic [15:0] addrBase = `UART_ADDR_BASE
) (
  input  logic            AClkH,
  input  logic            reset,
  input  uartPkg::ioReqT  ioReq,
  output logic [15:0]     ioMiso,
  output logic            ioAddrAck,
  output logic            ioAddrErr,
  output logic            irq,
  input  logic            rxPin,
  output logic            txPin
);

  uartPkg::uartCfgT cfg;

  // Send side
  logic       sendPush;
  logic       sendPop;
  logic       sendNotEmpty;
  logic       sendNotFull;
  logic       sendBusy;
  logic [7:0] sendHead;

  // Receive side
  logic             recvPush;
  logic             recvPop;
  logic             recvNotEmpty;
  uartPkg::rxFrameT recvIn;
  uartPkg::rxFrameT recvHead;

  uartRegs #(.addrBase(addrBase)) regs (
    .AClkH(AClkH), .reset(reset),
    .ioReq(ioReq), .ioMiso(ioMiso), .ioAddrAck(ioAddrAck), .ioAddrErr(ioAddrErr),
    .irq(irq), .cfg(cfg),
    .sendPush(sendPush), .sendNotFull(sendNotFull),
    .recvPop(recvPop), .recvHead(recvHead), .recvNotEmpty(recvNotEmpty),
    .sendBusy(sendBusy)
  );

  // Written byte goes straight from the bus into the send FIFO
  uartFifo #(.payloadT(logic [7:0])) sendFifo (
    .AClkH(AClkH), .reset(reset),
    .push(sendPush), .pushData(ioReq.ioMosi[7:0]),
    .pop(sendPop), .popData(sendHead),
    .notEmpty(sendNotEmpty), .notFull(sendNotFull)
  );

  uartFifo #(.payloadT(uartPkg::rxFrameT)) recvFifo (
    .AClkH(AClkH), .reset(reset),
    .push(recvPush), .pushData(recvIn),
    .pop(recvPop), .popData(recvHead),
    .notEmpty(recvNotEmpty), .notFull()
  );

  uartTx tx (
    .AClkH(AClkH), .reset(reset), .cfg(cfg),
    .sendData(sendHead), .sendReady(sendNotEmpty), .sendPop(sendPop),
    .busy(sendBusy), .txPin(txPin)
  );

  uartRx rx (
    .AClkH(AClkH), .reset(reset), .cfg(cfg),
    .rxPin(rxPin), .recvPush(recvPush), .recvData(recvIn)
  );

endmodule

//--- bench/ioUart_properties.sv
module ioUart_properties (
  input logic             AClkH,
  input logic             reset,
  input uartPkg::uartCfgT cfg,
  input logic             sendBusy,
  input logic [1:0]       irqEn,
  input logic             txPin,
  input logic             ioAddrAck,
  input logic             ioAddrErr,
  input logic             irq
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Idle line whenever the transmitter is off and quiet
  idleLineHigh: assert property (@(posedge AClkH) disable iff (reset)
    (!cfg.txEn && !sendBusy) |-> txPin)
    else begin
      failCount++;
      $error("txPin low while transmitter disabled and idle");
    end

  ackErrExclusive: assert property (@(posedge AClkH) disable iff (reset)
    !(ioAddrAck && ioAddrErr))
    else begin
      failCount++;
      $error("ioAddrAck and ioAddrErr high together");
    end

  irqMasked: assert property (@(posedge AClkH) disable iff (reset)
    (irqEn == 2'b00) |-> !irq)
    else begin
      failCount++;
      $error("irq high with all interrupt enables clear");
    end

endmodule

//--- bench/ioUartTb.sv
`include "uart_macros.svh"

module ioUartTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [15:0] BaseAddr = `UART_ADDR_BASE;
  localparam logic [15:0] CtrlAddr = BaseAddr + 16'(`UART_REG_CTRL);
  localparam logic [15:0] BaudAddr = BaseAddr + 16'(`UART_REG_BAUD);
  localparam logic [15:0] DataAddr = BaseAddr + 16'(`UART_REG_DATA);
  localparam logic [15:0] TxEnBit = 16'd1 << `UART_CTRL_TXEN;
  localparam logic [15:0] RxEnBit = 16'd1 << `UART_CTRL_RXEN;
  localparam logic [15:0] Stop2Bit = 16'd1 << `UART_CTRL_STOP2;
  localparam int TxBytes = 8;
  // Up to 32 frames of 11 bits at baud 20, plus polling margin
  localparam int WatchdogNs = 32 * 11 * 20 * 40 + 100000;

  logic           AClkH;
  logic           reset;
  uartPkg::ioReqT ioReq;
  logic [15:0]    ioMiso;
  logic           ioAddrAck;
  logic           ioAddrErr;
  logic           irq;
  logic           rxPin;
  logic           txPin;
  int             seed = 6391;
  int             checkErrors = 0;
  int             otherErrors = 0;
  logic [7:0]     txQueue[$];
  logic [8:0]     rxQueue[$];

  ioUart u_ioUart (
    .AClkH(AClkH), .reset(reset), .ioReq(ioReq), .ioMiso(ioMiso),
    .ioAddrAck(ioAddrAck), .ioAddrErr(ioAddrErr), .irq(irq),
    .rxPin(rxPin), .txPin(txPin)
  );

  bind ioUart ioUart_properties props (
    .AClkH(AClkH), .reset(reset), .cfg(cfg), .sendBusy(sendBusy), .irqEn(regs.irqEn),
    .txPin(txPin), .ioAddrAck(ioAddrAck), .ioAddrErr(ioAddrErr), .irq(irq)
  );

  initial begin
    AClkH = 1'b0;
    forever #20 AClkH = ~AClkH;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the tests finished");
    printErrorCounts();
    $display("Testbench failed");
    $finish;
  end

  task automatic printErrorCounts();
    $display("Errors: %0d failed checks, %0d other failures, %0d assertion failures",
             checkErrors, otherErrors, u_ioUart.props.failCount);
  endtask

  function automatic int randBelow(input int span);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % span;
  endfunction

  // Expected control read
  function automatic logic [15:0] ctrlWord(input logic txEn, input logic rxEn,
                                           input logic busy, input logic canWrite,
                                           input logic canRead);
    return {8'h00, txEn, rxEn, 2'b00, busy, 1'b0, canWrite, canRead};
  endfunction

  task automatic checkEq(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
    assert (actual === expected)
    else begin
      checkErrors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // One strobe cycle with outputs taken mid-cycle
  task automatic busAccess(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                           output logic [15:0] rdata, output logic ack, output logic err);
    @(posedge AClkH);
    ioReq <= '{ioAddr: addr, ioMosi: wdata, wr: wr, rd: ~wr};
    @(negedge AClkH);
    rdata = ioMiso;
    ack = ioAddrAck;
    err = ioAddrErr;
    @(posedge AClkH);
    ioReq <= '0;
  endtask

  task automatic busWrite(input logic [15:0] addr, input logic [15:0] wdata);
    logic [15:0] rdata;
    logic        ack;
    logic        err;
    busAccess(1'b1, addr, wdata, rdata, ack, err);
  endtask

  task automatic expectRead(input logic [15:0] addr, input logic [15:0] expected,
                            input string name);
    logic [15:0] rdata;
    logic        ack;
    logic        err;
    busAccess(1'b0, addr, 16'h0000, rdata, ack, err);
    checkEq(name, expected, rdata);
  endtask

  task automatic waitStatus(input int bitPos);
    logic [15:0] status;
    logic        ack;
    logic        err;
    status = '0;
    while (!status[bitPos]) busAccess(1'b0, CtrlAddr, 16'h0000, status, ack, err);
  endtask

  // Line model for the receive side
  task automatic sendSerial(input logic [7:0] data, input int baud, input logic stopLow);
    logic [9:0] frame;
    frame = {~stopLow, data, 1'b0};
    @(posedge AClkH);
    for (int i = 0; i < 10; i++) begin
      rxPin <= frame[i];
      repeat (baud) @(posedge AClkH);
    end
    rxPin <= 1'b1;
    repeat (baud) @(posedge AClkH);
  endtask

  task automatic drainRx();
    logic [8:0] expected;
    while (rxQueue.size() > 0) begin
      waitStatus(0);
      expected = rxQueue.pop_front();
      expectRead(DataAddr, {7'h00, expected}, "ioMiso data");
    end
  endtask

  // Line monitor where cycle 0 is the first low cycle of the start bit
  task automatic watchTx(input int nBytes, input int baud, input logic stop2);
    int         waited;
    int         stopLow;
    logic [7:0] got;
    for (int n = 0; n < nBytes; n++) begin
      waited = 0;
      @(negedge AClkH);
      while (txPin && waited < 40 * baud) begin
        @(negedge AClkH);
        waited++;
      end
      assert (!txPin)
      else begin
        otherErrors++;
        $display("Transmit frame never started, time %0t", $time);
        return;
      end
      repeat (baud / 2) @(negedge AClkH);
      checkEq("txPin start bit", 16'h0000, {15'h0, txPin});
      for (int i = 0; i < 8; i++) begin
        repeat (baud) @(negedge AClkH);
        got[i] = txPin;
      end
      repeat (baud - baud / 2) @(negedge AClkH);
      stopLow = 0;
      for (int c = 0; c < (stop2 ? 2 : 1) * baud; c++) begin
        if (c > 0) @(negedge AClkH);
        if (!txPin) stopLow++;
      end
      checkEq("txPin stop low cycles", 16'h0000, 16'(stopLow));
      assert (txQueue.size() > 0)
      else begin
        otherErrors++;
        $display("Transmit frame seen with no byte written, time %0t", $time);
        return;
      end
      checkEq("txPin data", {8'h00, txQueue.pop_front()}, {8'h00, got});
    end
  endtask

  initial begin
    int          baud;
    int          n;
    logic        stop2;
    logic [7:0]  b;
    logic [15:0] val;
    logic [15:0] rd;
    logic        ack;
    logic        err;
    reset = 1'b1;
    ioReq = '0;
    rxPin = 1'b1;
    repeat (5) @(posedge AClkH);
    reset <= 1'b0;

    // Registers and reset values
    expectRead(CtrlAddr, ctrlWord(0, 0, 0, 1, 0), "ioMiso ctrl after reset");
    @(negedge AClkH);
    checkEq("irq", 16'h0000, {15'h0, irq});
    checkEq("txPin", 16'h0001, {15'h0, txPin});
    repeat (4) begin
      val = 16'(randBelow(65536));
      busWrite(BaudAddr, val);
      expectRead(BaudAddr, val, "ioMiso baud");
      // TxEn kept clear
      // IrqEn bit 1 follows CanWrite
      b = 8'(randBelow(256)) & 8'h4B;
      busWrite(CtrlAddr, {8'h00, b});
      expectRead(CtrlAddr, ctrlWord(0, b[6], 0, 1, 0), "ioMiso ctrl");
      @(negedge AClkH);
      checkEq("irq", {15'h0, b[1]}, {15'h0, irq});
      checkEq("txPin", 16'h0001, {15'h0, txPin});
    end
    busWrite(CtrlAddr, 16'h0000);

    // Transmit path
    baud = 8 + randBelow(13);
    stop2 = randBelow(2) == 1;
    busWrite(BaudAddr, 16'(baud));
    busWrite(CtrlAddr, TxEnBit | (stop2 ? Stop2Bit : 16'h0000));
    fork
      watchTx(TxBytes, baud, stop2);
      repeat (TxBytes) begin
        waitStatus(1);
        b = 8'(randBelow(256));
        txQueue.push_back(b);
        busWrite(DataAddr, {8'h00, b});
      end
    join
    checkEq("bytes never sent", 16'h0000, 16'(txQueue.size()));
    busWrite(CtrlAddr, RxEnBit);

    // Receive path with at most one FIFO load per round
    repeat (3) begin
      n = 1 + randBelow(`UART_FIFO_DEPTH);
      repeat (n) begin
        b = 8'(randBelow(256));
        rxQueue.push_back({1'b0, b});
        sendSerial(b, baud, 1'b0);
      end
      drainRx();
    end
    expectRead(DataAddr, 16'h0000, "ioMiso empty data");
    expectRead(CtrlAddr, ctrlWord(0, 1, 0, 1, 0), "ioMiso ctrl drained");

    // Stop bit driven low
    b = 8'(randBelow(256));
    rxQueue.push_back({1'b1, b});
    sendSerial(b, baud, 1'b1);
    drainRx();

    // Send FIFO fills while TxEn is clear and drops the fifth byte
    busWrite(CtrlAddr, 16'h0000);
    repeat (`UART_FIFO_DEPTH) begin
      b = 8'(randBelow(256));
      txQueue.push_back(b);
      busWrite(DataAddr, {8'h00, b});
    end
    expectRead(CtrlAddr, ctrlWord(0, 0, 0, 0, 0), "ioMiso ctrl full");
    busWrite(DataAddr, 16'h00A5);
    fork
      watchTx(`UART_FIFO_DEPTH, baud, stop2);
      begin
        busWrite(CtrlAddr, TxEnBit | (stop2 ? Stop2Bit : 16'h0000));
        // First byte popped, frame under way
        expectRead(CtrlAddr, ctrlWord(1, 0, 1, 1, 0), "ioMiso ctrl sending");
      end
    join
    expectRead(CtrlAddr, ctrlWord(1, 0, 0, 1, 0), "ioMiso ctrl after drain");
    checkEq("bytes never sent", 16'h0000, 16'(txQueue.size()));

    // IrqEn 01 follows CanRead
    busWrite(CtrlAddr, RxEnBit | 16'h0001);
    @(negedge AClkH);
    checkEq("irq before receive", 16'h0000, {15'h0, irq});
    b = 8'(randBelow(256));
    sendSerial(b, baud, 1'b0);
    waitStatus(0);
    @(negedge AClkH);
    checkEq("irq after receive", 16'h0001, {15'h0, irq});
    expectRead(DataAddr, {8'h00, b}, "ioMiso data");
    repeat (2) @(negedge AClkH);
    checkEq("irq after read", 16'h0000, {15'h0, irq});
    busWrite(CtrlAddr, 16'h0000);

    // Address decode
    for (int off = 0; off < 4; off++) begin
      busAccess(1'b0, BaseAddr + 16'(off), 16'h0000, rd, ack, err);
      checkEq("ioAddrAck", {15'h0, off < 3}, {15'h0, ack});
      checkEq("ioAddrErr", {15'h0, off == 3}, {15'h0, err});
    end
    busAccess(1'b1, BaseAddr + 16'd3, 16'(randBelow(65536)), rd, ack, err);
    checkEq("ioAddrErr write", 16'h0001, {15'h0, err});
    checkEq("ioAddrAck write", 16'h0000, {15'h0, ack});
    repeat (8) begin
      val = 16'(randBelow(65536));
      if (val - BaseAddr < 16'd4) val = BaseAddr - 16'd1;
      busAccess(randBelow(2) == 1, val, 16'(randBelow(65536)), rd, ack, err);
      checkEq("ioAddrAck outside", 16'h0000, {15'h0, ack});
      checkEq("ioAddrErr outside", 16'h0000, {15'h0, err});
      checkEq("ioMiso outside", 16'h0000, rd);
    end

    printErrorCounts();
    if (checkErrors + otherErrors + u_ioUart.props.failCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
logic/uartPkg.sv
logic/uartFifo.sv
logic/uartTx.sv
logic/uartRx.sv
logic/uartRegs.sv
logic/ioUart.sv
bench/ioUart_properties.sv
bench/ioUartTb.sv

//--- Makefile
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP       ?= ioUartTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
	  echo "Simulation did not pass, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
